/* sources.f */
hdl/rv_decode_pkg.sv
hdl/instr_decoder.sv
hdl/operand_forward.sv
hdl/branch_unit.sv
hdl/id_ex_reg.sv
hdl/id_stage.sv
dv/id_stage_chk.sv
dv/tb_id_stage.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - hdl/rv_decode_pkg.sv
  - hdl/instr_decoder.sv
  - hdl/operand_forward.sv
  - hdl/branch_unit.sv
  - hdl/id_ex_reg.sv
  - hdl/id_stage.sv
  - target: test
    files:
      - dv/id_stage_chk.sv
      - dv/tb_id_stage.sv

/* dv/tb_id_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_id_stage
    import rv_decode_pkg::*;
();

    localparam int NUM_CYCLES     = 2000;
    localparam int RESET_CYCLES   = 5;
    localparam int TIMEOUT_CYCLES = NUM_CYCLES + RESET_CYCLES + 50;

    // kept major opcodes for random instructions.
    localparam logic [6:0] OPCODES [7] = '{
        7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111,
        7'b1100011, 7'b0010011, 7'b0110011
    };

    logic     clk;
    logic     rst_n;
    logic     rdy;
    xlen_t    pc;
    xlen_t    instr;
    xlen_t    rf_rdata1;
    xlen_t    rf_rdata2;
    fwd_src_t ex_fwd;
    fwd_src_t mem_fwd;
    reg_req_t rf_req1;
    reg_req_t rf_req2;
    branch_t  branch;
    id_ex_t   id_ex;

    logic [31:0] rng_state;
    int          err_cnt;
    int          check_cnt;
    int          cycle_cnt;
    reg_req_t    exp_req1;
    reg_req_t    exp_req2;
    branch_t     exp_branch;
    id_ex_t      exp_q[$];

    id_stage DUT (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .rdy_i       (rdy),
        .pc_i        (pc),
        .instr_i     (instr),
        .rf_rdata1_i (rf_rdata1),
        .rf_rdata2_i (rf_rdata2),
        .ex_fwd_i    (ex_fwd),
        .mem_fwd_i   (mem_fwd),
        .rf_req1_o   (rf_req1),
        .rf_req2_o   (rf_req2),
        .branch_o    (branch),
        .id_ex_o     (id_ex)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] rand_word();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic reg_addr_t pick_fwd_addr(input logic [1:0] sel);
        logic [31:0] w;
        w = rand_word();
        case (sel)
            2'd1:    return instr[24:20];
            2'd2:    return w[4:0];
            default: return instr[19:15];
        endcase
    endfunction

    // execute over memory over register file, x0 forced to zero.
    function automatic xlen_t fwd_operand(input logic rd, input reg_addr_t addr,
                                          input xlen_t rf, input xlen_t imm);
        if (!rd)
            return imm;
        if (ex_fwd.wreg && ex_fwd.wd == addr)
            return (addr == 5'd0) ? 32'd0 : ex_fwd.wdata;
        if (mem_fwd.wreg && mem_fwd.wd == addr)
            return (addr == 5'd0) ? 32'd0 : mem_fwd.wdata;
        return rf;
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_cnt++;
        assert (act === exp)
        else
        begin
            err_cnt++;
            $display("Mismatch at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    task automatic check_id_ex(input id_ex_t exp);
        compare("id_ex_o.aluop", exp.aluop, id_ex.aluop);
        compare("id_ex_o.alusel", exp.alusel, id_ex.alusel);
        compare("id_ex_o.op1", exp.op1, id_ex.op1);
        compare("id_ex_o.op2", exp.op2, id_ex.op2);
        compare("id_ex_o.wd", exp.wd, id_ex.wd);
        compare("id_ex_o.wreg", exp.wreg, id_ex.wreg);
        compare("id_ex_o.link_addr", exp.link_addr, id_ex.link_addr);
    endtask

    task automatic predict();
        logic [6:0] opc;
        logic [2:0] f3;
        xlen_t      imm_u;
        xlen_t      imm_i;
        xlen_t      off_j;
        xlen_t      off_b;
        xlen_t      imm1;
        xlen_t      imm2;
        xlen_t      op1;
        xlen_t      op2;
        alu_op_e    op;
        alu_sel_e   sel;
        logic       wreg;
        logic       rd1;
        logic       rd2;
        logic       cond;
        branch_t    br;
        id_ex_t     q;
        opc   = instr[6:0];
        f3    = instr[14:12];
        imm_u = {instr[31:12], 12'h000};
        imm_i = {{20{instr[31]}}, instr[31:20]};
        off_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        off_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        op    = ALU_NOP;
        sel   = SEL_NOP;
        wreg  = 1'b0;
        rd1   = 1'b0;
        rd2   = 1'b0;
        imm1  = '0;
        imm2  = '0;
        if (rdy)
        begin
            case (opc)
                7'b0110111:
                begin
                    op   = ALU_LUI;
                    sel  = SEL_LOGIC;
                    wreg = 1'b1;
                    imm1 = imm_u;
                end
                7'b0010111:
                begin
                    op   = ALU_ADD;
                    sel  = SEL_ARITH;
                    wreg = 1'b1;
                    imm1 = imm_u;
                    imm2 = pc;
                end
                7'b1101111:
                begin
                    op   = ALU_JAL;
                    sel  = SEL_JUMP_BRANCH;
                    wreg = 1'b1;
                end
                7'b1100111:
                begin
                    op   = ALU_JALR;
                    sel  = SEL_JUMP_BRANCH;
                    wreg = 1'b1;
                    rd1  = 1'b1;
                    imm2 = imm_i;
                end
                7'b0010011, 7'b0110011:
                begin
                    wreg = 1'b1;
                    rd1  = 1'b1;
                    rd2  = (opc == 7'b0110011);
                    imm2 = imm_i;
                    case (f3)
                        3'd0:    op = (rd2 && instr[30]) ? ALU_SUB : ALU_ADD;
                        3'd1:    op = ALU_SLL;
                        3'd2:    op = ALU_SLT;
                        3'd3:    op = ALU_SLTU;
                        3'd4:    op = ALU_XOR;
                        3'd5:    op = instr[30] ? ALU_SRA : ALU_SRL;
                        3'd6:    op = ALU_OR;
                        default: op = ALU_AND;
                    endcase
                    if (f3 == 3'd1 || f3 == 3'd5)
                    begin
                        sel  = SEL_SHIFT;
                        imm2 = {27'b0, instr[24:20]};  // shamt.
                    end
                    else if (f3 == 3'd4 || f3 == 3'd6 || f3 == 3'd7)
                        sel = SEL_LOGIC;
                    else
                        sel = SEL_ARITH;
                end
                7'b1100011:
                begin
                    case (f3)
                        3'd0:    op = ALU_BEQ;
                        3'd1:    op = ALU_BNE;
                        3'd4:    op = ALU_BLT;
                        3'd5:    op = ALU_BGE;
                        3'd6:    op = ALU_BLTU;
                        3'd7:    op = ALU_BGEU;
                        default: op = ALU_NOP;
                    endcase
                    if (op != ALU_NOP)
                    begin
                        sel = SEL_JUMP_BRANCH;
                        rd1 = 1'b1;
                        rd2 = 1'b1;
                    end
                end
                default:
                    op = ALU_NOP;
            endcase
        end
        exp_req1.read = rd1;
        exp_req1.addr = rdy ? instr[19:15] : 5'd0;
        exp_req2.read = rd2;
        exp_req2.addr = rdy ? instr[24:20] : 5'd0;
        op1 = fwd_operand(rd1, exp_req1.addr, rf_rdata1, imm1);
        op2 = fwd_operand(rd2, exp_req2.addr, rf_rdata2, imm2);
        case (op)
            ALU_BEQ:  cond = (op1 == op2);
            ALU_BNE:  cond = (op1 != op2);
            ALU_BLT:  cond = ($signed(op1) < $signed(op2));
            ALU_BGE:  cond = ($signed(op1) >= $signed(op2));
            ALU_BLTU: cond = (op1 < op2);
            ALU_BGEU: cond = (op1 >= op2);
            default:  cond = 1'b0;
        endcase
        br = '0;
        if (op == ALU_JAL || op == ALU_JALR)
        begin
            br.taken     = 1'b1;
            br.target    = (op == ALU_JAL) ? pc + off_j : op1 + imm_i;
            br.link_addr = pc + 32'd4;
        end
        else if (cond)
        begin
            br.taken  = 1'b1;
            br.target = pc + off_b;
        end
        exp_branch = br;
        q = '0;
        if (rdy)
            q = '{aluop: op, alusel: sel, op1: op1, op2: op2, wd: instr[11:7],
                  wreg: wreg, link_addr: br.link_addr};
        exp_q.push_back(q);
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        logic [31:0] word;
        r    = rand_word();
        word = rand_word();
        if (r[3:0] == 4'd0)
            instr = word;  // occasional raw word.
        else
            instr = {word[31:7], OPCODES[r[3:0] % 7]};
        if (r[6:4] == 3'd0)
            instr[19:15] = 5'd0;
        if (instr[6:0] == 7'b1100111)
            instr[14:12] = 3'd0;
        pc           = rand_word();
        rf_rdata1    = rand_word();
        rf_rdata2    = (r[8:7] == 2'd0) ? rf_rdata1 : rand_word();
        ex_fwd.wreg  = r[9] | r[10];
        ex_fwd.wd    = pick_fwd_addr(r[12:11]);
        ex_fwd.wdata = rand_word();
        mem_fwd.wreg  = r[13] | r[14];
        mem_fwd.wd    = pick_fwd_addr(r[16:15]);
        mem_fwd.wdata = rand_word();
        rdy = (r[19:17] != 3'd0);  // low about one cycle in eight.
        predict();
    endtask

    task automatic check_outputs();
        id_ex_t exp;
        compare("rf_req1_o", exp_req1, rf_req1);
        compare("rf_req2_o", exp_req2, rf_req2);
        compare("branch_o.taken", exp_branch.taken, branch.taken);
        compare("branch_o.target", exp_branch.target, branch.target);
        compare("branch_o.link_addr", exp_branch.link_addr, branch.link_addr);
        exp = exp_q.pop_front();
        check_id_ex(exp);
    endtask

    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
        $display("Test failed");
        $finish;
    end

    initial
    begin
        rng_state = 32'hc374cd10;
        err_cnt   = 0;
        check_cnt = 0;
        rst_n     = 1'b1;
        rdy       = 1'b0;
        pc        = '0;
        instr     = '0;
        rf_rdata1 = '0;
        rf_rdata2 = '0;
        ex_fwd    = '0;
        mem_fwd   = '0;
        #1;
        rst_n = 1'b0;  // falling edge clears id_ex_o.
        repeat (RESET_CYCLES)
        begin
            @(posedge clk);
            #1;
            check_id_ex('0);  // bubble under reset.
        end
        rst_n = 1'b1;
        drive_inputs();
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++)
        begin
            @(posedge clk);
            #1;
            check_outputs();
            if (cyc < NUM_CYCLES - 1)
                drive_inputs();
        end
        $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/id_stage_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module id_stage_chk
    import rv_decode_pkg::*;
(
    input wire           clk_i,
    input wire           rst_n_i,
    input wire           rdy_i,
    input wire reg_req_t rf_req1_i,
    input wire reg_req_t rf_req2_i,
    input wire branch_t  branch_i,
    input wire id_ex_t   id_ex_i
);

    logic bubble;

    assign bubble = (id_ex_i.aluop == ALU_NOP) && (id_ex_i.alusel == SEL_NOP)
                    && !id_ex_i.wreg && (id_ex_i.op1 == '0) && (id_ex_i.op2 == '0)
                    && (id_ex_i.wd == '0) && (id_ex_i.link_addr == '0);

    reset_no_write: assert property (@(posedge clk_i) !rst_n_i |-> !id_ex_i.wreg)
        else $error("id_ex_o.wreg is set during reset");

    // idle stage requests nothing.
    idle_quiet: assert property (@(posedge clk_i)
        !rdy_i |-> !branch_i.taken && !rf_req1_i.read && !rf_req2_i.read)
        else $error("branch taken or register read while rdy_i is low");

    idle_bubble: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !rdy_i |=> bubble)
        else $error("id_ex_o is not a bubble after a cycle with rdy_i low");

endmodule

bind id_stage id_stage_chk u_chk (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .rdy_i     (rdy_i),
    .rf_req1_i (rf_req1_o),
    .rf_req2_i (rf_req2_o),
    .branch_i  (branch_o),
    .id_ex_i   (id_ex_o)
);

`default_nettype wire

/* hdl/id_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module id_stage
    import rv_decode_pkg::*;
(
    input  wire           clk_i,
    input  wire           rst_n_i,
    input  wire           rdy_i,
    input  wire xlen_t    pc_i,
    input  wire xlen_t    instr_i,
    input  wire xlen_t    rf_rdata1_i,
    input  wire xlen_t    rf_rdata2_i,
    input  wire fwd_src_t ex_fwd_i,
    input  wire fwd_src_t mem_fwd_i,
    output reg_req_t      rf_req1_o,
    output reg_req_t      rf_req2_o,
    output branch_t       branch_o,
    output id_ex_t        id_ex_o
);

    dec_ctrl_t ctrl;
    xlen_t     op1;
    xlen_t     op2;
    id_ex_t    id_ex_d;

    instr_decoder u_decoder (
        .instr_i (instr_i),
        .pc_i    (pc_i),
        .rdy_i   (rdy_i),
        .ctrl_o  (ctrl)
    );

    assign rf_req1_o = ctrl.rs1;
    assign rf_req2_o = ctrl.rs2;

    operand_forward u_fwd_op1 (
        .req_i      (ctrl.rs1),
        .rf_rdata_i (rf_rdata1_i),
        .imm_i      (ctrl.imm1),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .operand_o  (op1)
    );

    operand_forward u_fwd_op2 (
        .req_i      (ctrl.rs2),
        .rf_rdata_i (rf_rdata2_i),
        .imm_i      (ctrl.imm2),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .operand_o  (op2)
    );

    // jalr target uses the forwarded rs1.
    branch_unit u_branch (
        .aluop_i   (ctrl.aluop),
        .op1_i     (op1),
        .op2_i     (op2),
        .rs1_fwd_i (op1),
        .instr_i   (instr_i),
        .pc_i      (pc_i),
        .branch_o  (branch_o)
    );

    assign id_ex_d = '{
        aluop:     ctrl.aluop,
        alusel:    ctrl.alusel,
        op1:       op1,
        op2:       op2,
        wd:        ctrl.wd,
        wreg:      ctrl.wreg,
        link_addr: branch_o.link_addr
    };

    id_ex_reg u_id_ex (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .rdy_i   (rdy_i),
        .d_i     (id_ex_d),
        .q_o     (id_ex_o)
    );

endmodule

`default_nettype wire

/* hdl/id_ex_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module id_ex_reg
    import rv_decode_pkg::*;
(
    input  wire         clk_i,
    input  wire         rst_n_i,
    input  wire         rdy_i,
    input  wire id_ex_t d_i,
    output id_ex_t      q_o
);

    localparam id_ex_t BUBBLE = '{
        aluop:     ALU_NOP,
        alusel:    SEL_NOP,
        op1:       '0,
        op2:       '0,
        wd:        '0,
        wreg:      1'b0,
        link_addr: '0
    };

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            q_o <= BUBBLE;
        end
        else if (!rdy_i)
        begin
            q_o <= BUBBLE;  // no instruction this cycle.
        end
        else
        begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

/* hdl/branch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module branch_unit
    import rv_decode_pkg::*;
(
    input  wire alu_op_e aluop_i,
    input  wire xlen_t   op1_i,
    input  wire xlen_t   op2_i,
    input  wire xlen_t   rs1_fwd_i,
    input  wire xlen_t   instr_i,
    input  wire xlen_t   pc_i,
    output branch_t      branch_o
);

    xlen_t off_j;
    xlen_t off_b;
    xlen_t off_i;
    xlen_t pc_plus4;
    logic  cond;

    assign off_j    = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
    assign off_b    = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign off_i    = {{20{instr_i[31]}}, instr_i[31:20]};
    assign pc_plus4 = pc_i + 32'd4;

    always_comb
    begin
        case (aluop_i)
            ALU_BEQ:  cond = (op1_i == op2_i);
            ALU_BNE:  cond = (op1_i != op2_i);
            ALU_BLT:  cond = ($signed(op1_i) < $signed(op2_i));
            ALU_BGE:  cond = ($signed(op1_i) >= $signed(op2_i));
            ALU_BLTU: cond = (op1_i < op2_i);
            ALU_BGEU: cond = (op1_i >= op2_i);
            default:  cond = 1'b0;
        endcase
    end

    always_comb
    begin
        branch_o = '0;
        case (aluop_i)
            ALU_JAL:
            begin
                branch_o.taken     = 1'b1;
                branch_o.target    = pc_i + off_j;
                branch_o.link_addr = pc_plus4;
            end
            ALU_JALR:
            begin
                branch_o.taken     = 1'b1;
                branch_o.target    = rs1_fwd_i + off_i;  // lsb kept as is.
                branch_o.link_addr = pc_plus4;
            end
            default:
            begin
                if (cond)
                begin
                    branch_o.taken  = 1'b1;
                    branch_o.target = pc_i + off_b;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/operand_forward.sv */
`timescale 1ns/100ps
`default_nettype none

module operand_forward
    import rv_decode_pkg::*;
(
    input  wire reg_req_t req_i,
    input  wire xlen_t    rf_rdata_i,
    input  wire xlen_t    imm_i,
    input  wire fwd_src_t ex_fwd_i,
    input  wire fwd_src_t mem_fwd_i,
    output xlen_t         operand_o
);

    logic ex_hit;
    logic mem_hit;
    logic addr_zero;

    assign ex_hit    = ex_fwd_i.wreg && (ex_fwd_i.wd == req_i.addr);
    assign mem_hit   = mem_fwd_i.wreg && (mem_fwd_i.wd == req_i.addr);
    assign addr_zero = (req_i.addr == '0);

    always_comb
    begin
        if (!req_i.read)
        begin
            operand_o = imm_i;
        end
        else if (ex_hit)
        begin
            operand_o = addr_zero ? '0 : ex_fwd_i.wdata;  // x0 stays zero.
        end
        else if (mem_hit)
        begin
            operand_o = addr_zero ? '0 : mem_fwd_i.wdata;
        end
        else
        begin
            operand_o = rf_rdata_i;
        end
    end

endmodule

`default_nettype wire

/* hdl/instr_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module instr_decoder
    import rv_decode_pkg::*;
(
    input  wire xlen_t instr_i,
    input  wire xlen_t pc_i,
    input  wire        rdy_i,
    output dec_ctrl_t  ctrl_o
);

    opcode_e    opcode;
    logic [2:0] funct3;
    xlen_t      imm_u;
    xlen_t      imm_i;
    xlen_t      imm_shamt;
    alu_op_e    f3_op;
    alu_sel_e   f3_sel;
    alu_op_e    br_op;

    assign opcode    = opcode_e'(instr_i[6:0]);
    assign funct3    = instr_i[14:12];
    assign imm_u     = {instr_i[31:12], 12'b0};
    assign imm_i     = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_shamt = {27'b0, instr_i[24:20]};

    // alu op shared by OP and OP-IMM.
    always_comb
    begin
        case (funct3)
            3'b000:
            begin
                f3_op  = (opcode == OPC_OP && instr_i[30]) ? ALU_SUB : ALU_ADD;
                f3_sel = SEL_ARITH;
            end
            3'b001:
            begin
                f3_op  = ALU_SLL;
                f3_sel = SEL_SHIFT;
            end
            3'b010:
            begin
                f3_op  = ALU_SLT;
                f3_sel = SEL_ARITH;
            end
            3'b011:
            begin
                f3_op  = ALU_SLTU;
                f3_sel = SEL_ARITH;
            end
            3'b100:
            begin
                f3_op  = ALU_XOR;
                f3_sel = SEL_LOGIC;
            end
            3'b101:
            begin
                f3_op  = instr_i[30] ? ALU_SRA : ALU_SRL;
                f3_sel = SEL_SHIFT;
            end
            3'b110:
            begin
                f3_op  = ALU_OR;
                f3_sel = SEL_LOGIC;
            end
            default:
            begin
                f3_op  = ALU_AND;
                f3_sel = SEL_LOGIC;
            end
        endcase
    end

    always_comb
    begin
        case (funct3)
            3'b000:  br_op = ALU_BEQ;
            3'b001:  br_op = ALU_BNE;
            3'b100:  br_op = ALU_BLT;
            3'b101:  br_op = ALU_BGE;
            3'b110:  br_op = ALU_BLTU;
            3'b111:  br_op = ALU_BGEU;
            default: br_op = ALU_NOP;  // 010 and 011 undefined.
        endcase
    end

    always_comb
    begin
        ctrl_o        = '0;
        ctrl_o.aluop  = ALU_NOP;
        ctrl_o.alusel = SEL_NOP;
        if (rdy_i)
        begin
            ctrl_o.wd       = instr_i[11:7];
            ctrl_o.rs1.addr = instr_i[19:15];
            ctrl_o.rs2.addr = instr_i[24:20];
            case (opcode)
                OPC_LUI:
                begin
                    ctrl_o.aluop  = ALU_LUI;
                    ctrl_o.alusel = SEL_LOGIC;
                    ctrl_o.wreg   = 1'b1;
                    ctrl_o.imm1   = imm_u;
                end
                OPC_AUIPC:
                begin
                    ctrl_o.aluop  = ALU_ADD;
                    ctrl_o.alusel = SEL_ARITH;
                    ctrl_o.wreg   = 1'b1;
                    ctrl_o.imm1   = imm_u;
                    ctrl_o.imm2   = pc_i;
                end
                OPC_JAL:
                begin
                    ctrl_o.aluop  = ALU_JAL;
                    ctrl_o.alusel = SEL_JUMP_BRANCH;
                    ctrl_o.wreg   = 1'b1;
                end
                OPC_JALR:
                begin
                    ctrl_o.aluop    = ALU_JALR;
                    ctrl_o.alusel   = SEL_JUMP_BRANCH;
                    ctrl_o.wreg     = 1'b1;
                    ctrl_o.rs1.read = 1'b1;
                    ctrl_o.imm2     = imm_i;
                end
                OPC_BRANCH:
                begin
                    ctrl_o.aluop = br_op;
                    if (br_op != ALU_NOP)
                    begin
                        ctrl_o.alusel   = SEL_JUMP_BRANCH;
                        ctrl_o.rs1.read = 1'b1;
                        ctrl_o.rs2.read = 1'b1;
                    end
                end
                OPC_OP_IMM:
                begin
                    ctrl_o.aluop    = f3_op;
                    ctrl_o.alusel   = f3_sel;
                    ctrl_o.wreg     = 1'b1;
                    ctrl_o.rs1.read = 1'b1;
                    ctrl_o.imm2     = (f3_sel == SEL_SHIFT) ? imm_shamt : imm_i;
                end
                OPC_OP:
                begin
                    ctrl_o.aluop    = f3_op;
                    ctrl_o.alusel   = f3_sel;
                    ctrl_o.wreg     = 1'b1;
                    ctrl_o.rs1.read = 1'b1;
                    ctrl_o.rs2.read = 1'b1;
                end
                default:
                begin
                    ctrl_o.aluop = ALU_NOP;  // unknown opcode.
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/rv_decode_pkg.sv */
`default_nettype none

package rv_decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // kept rv32i major opcodes.
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_NOP  = 5'd0,
        ALU_OR   = 5'd1,
        ALU_XOR  = 5'd2,
        ALU_AND  = 5'd3,
        ALU_SLL  = 5'd4,
        ALU_SRL  = 5'd5,
        ALU_SRA  = 5'd6,
        ALU_ADD  = 5'd7,
        ALU_SUB  = 5'd8,
        ALU_SLT  = 5'd9,
        ALU_SLTU = 5'd10,
        ALU_LUI  = 5'd11,
        ALU_JAL  = 5'd12,
        ALU_JALR = 5'd13,
        ALU_BEQ  = 5'd14,
        ALU_BNE  = 5'd15,
        ALU_BLT  = 5'd16,
        ALU_BGE  = 5'd17,
        ALU_BLTU = 5'd18,
        ALU_BGEU = 5'd19
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NOP         = 3'd0,
        SEL_LOGIC       = 3'd1,
        SEL_SHIFT       = 3'd2,
        SEL_ARITH       = 3'd3,
        SEL_JUMP_BRANCH = 3'd4
    } alu_sel_e;

    typedef struct packed {
        logic      wreg;
        reg_addr_t wd;
        xlen_t     wdata;
    } fwd_src_t;

    typedef struct packed {
        logic      read;
        reg_addr_t addr;
    } reg_req_t;

    typedef struct packed {
        alu_op_e   aluop;
        alu_sel_e  alusel;
        reg_req_t  rs1;
        reg_req_t  rs2;
        reg_addr_t wd;
        logic      wreg;
        xlen_t     imm1;  // operand 1 when rs1 is not read.
        xlen_t     imm2;  // operand 2 when rs2 is not read.
    } dec_ctrl_t;

    typedef struct packed {
        logic  taken;
        xlen_t target;
        xlen_t link_addr;
    } branch_t;

    typedef struct packed {
        alu_op_e   aluop;
        alu_sel_e  alusel;
        xlen_t     op1;
        xlen_t     op2;
        reg_addr_t wd;
        logic      wreg;
        xlen_t     link_addr;
    } id_ex_t;

endpackage

`default_nettype wire
